/* lsu_bus_master.sv */
`timescale 1ns/1ps

module lsu_bus_master (
	input  logic                       clk,
	input  logic                       rst_i,
	input  logic                       start_i,
	input  logic                       is_store_i,
	input  logic [lsu_pkg::DATA_W-1:0] addr_i,
	input  logic [lsu_pkg::SEL_W-1:0]  sel_i,
	input  logic [lsu_pkg::DATA_W-1:0] store_lanes_i,
	output logic                       wb_cyc_o,
	output logic                       wb_stb_o,
	output logic                       wb_we_o,
	output logic [lsu_pkg::DATA_W-1:0] wb_adr_o,
	output logic [lsu_pkg::SEL_W-1:0]  wb_sel_o,
	output logic [lsu_pkg::DATA_W-1:0] wb_dat_o,
	input  logic                       wb_ack_i,
	output logic                       bus_done_o
);
	import lsu_pkg::*;

	logic state_q;
	logic state_d;
	logic cyc;

	////////////////////////////////////////
	// cycle control
	////////////////////////////////////////

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			BM_IDLE:
			begin
				// a zero wait state ack ends the cycle right away
				if (start_i && !wb_ack_i)
					state_d = BM_WAIT;
			end
			BM_WAIT:
			begin
				if (wb_ack_i)
					state_d = BM_IDLE;
			end
			default:
				state_d = BM_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			state_q <= BM_IDLE;
		else
			state_q <= state_d;
	end

	// cycle opens with the start strobe, held until ack
	assign cyc = start_i | (state_q == BM_WAIT);

	////////////////////////////////////////
	// bus outputs
	////////////////////////////////////////

	assign wb_cyc_o = cyc;
	assign wb_stb_o = cyc;
	assign wb_we_o  = cyc & is_store_i;
	// word address, lanes picked by sel
	assign wb_adr_o = {addr_i[DATA_W-1:2], 2'b00};
	assign wb_sel_o = cyc ? sel_i : {SEL_W{1'b0}};
	assign wb_dat_o = store_lanes_i;

	assign bus_done_o = cyc & wb_ack_i;

endmodule

/* lsu_decode.sv */
`timescale 1ns/1ps

module lsu_decode (
	input  logic                       clk,
	input  logic                       rst_i,
	input  logic                       accept_i,
	input  logic [lsu_pkg::OP_W-1:0]   op_i,
	input  logic [lsu_pkg::DATA_W-1:0] addr_i,
	input  logic [lsu_pkg::DATA_W-1:0] store_data_i,
	input  logic                       link_i,
	output logic                       is_load_o,
	output logic                       is_store_o,
	output logic                       is_signed_o,
	output logic                       size_byte_o,
	output logic                       size_half_o,
	output logic                       is_ll_o,
	output logic                       is_sc_o,
	output logic                       start_o,
	output logic                       skip_o,
	output logic [lsu_pkg::SEL_W-1:0]  sel_o,
	output logic [lsu_pkg::DATA_W-1:0] store_lanes_o,
	output logic [lsu_pkg::DATA_W-1:0] addr_o,
	output logic                       fault_o
);
	import lsu_pkg::*;

	logic             load_d;
	logic             store_d;
	logic             signed_d;
	logic             byte_d;
	logic             half_d;
	logic             word_d;
	logic             fault_d;
	logic             start_d;
	logic [SEL_W-1:0] sel_d;
	mem_word_u        lanes_d;

	////////////////////////////////////////
	// operation decode
	////////////////////////////////////////

	assign load_d   = op_i inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LL};
	assign store_d  = op_i inside {OP_SB, OP_SH, OP_SW, OP_SC};
	assign signed_d = op_i inside {OP_LB, OP_LH};
	assign byte_d   = op_i inside {OP_LB, OP_LBU, OP_SB};
	assign half_d   = op_i inside {OP_LH, OP_LHU, OP_SH};
	assign word_d   = (load_d | store_d) & ~byte_d & ~half_d;

	// natural alignment only
	assign fault_d = (half_d & addr_i[0]) | (word_d & (addr_i[1:0] != 2'b00));

	// SC without a live link never reaches the bus
	assign start_d = (load_d | store_d) & ~fault_d & ~((op_i == OP_SC) & ~link_i);

	// byte selects and replicated store data
	always_comb
	begin
		lanes_d = store_data_i;
		if (byte_d)
		begin
			sel_d = 4'b0001 << addr_i[1:0];
			lanes_d.bytes = {SEL_W{store_data_i[7:0]}};
		end
		else if (half_d)
		begin
			sel_d = addr_i[1] ? 4'b1100 : 4'b0011;
			lanes_d.halves = {2{store_data_i[DATA_W/2-1:0]}};
		end
		else
			sel_d = {SEL_W{1'b1}};
	end

	////////////////////////////////////////
	// request capture
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			is_load_o   <= 1'b0;
			is_store_o  <= 1'b0;
			is_signed_o <= 1'b0;
			size_byte_o <= 1'b0;
			size_half_o <= 1'b0;
			is_ll_o     <= 1'b0;
			is_sc_o     <= 1'b0;
			fault_o     <= 1'b0;
			start_o     <= 1'b0;
			skip_o      <= 1'b0;
		end
		else if (accept_i)
		begin
			is_load_o   <= load_d;
			is_store_o  <= store_d;
			is_signed_o <= signed_d;
			size_byte_o <= byte_d;
			size_half_o <= half_d;
			is_ll_o     <= (op_i == OP_LL);
			is_sc_o     <= (op_i == OP_SC);
			fault_o     <= fault_d;
			start_o     <= start_d;
			skip_o      <= ~start_d;
		end
		else
		begin
			// one cycle strobes
			start_o <= 1'b0;
			skip_o  <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept_i)
		begin
			addr_o        <= addr_i;
			sel_o         <= sel_d;
			store_lanes_o <= lanes_d;
		end
	end

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int DATA_W     = 32;
	localparam int SEL_W      = 4;
	localparam int REG_ADDR_W = 5;
	localparam int OP_W       = 4;
	localparam int EXC_W      = 5;

	////////////////////////////////////////
	// operation codes
	////////////////////////////////////////

	// anything not listed here is a no-op
	localparam logic [OP_W-1:0] OP_LB  = 4'h1;
	localparam logic [OP_W-1:0] OP_LBU = 4'h2;
	localparam logic [OP_W-1:0] OP_LH  = 4'h3;
	localparam logic [OP_W-1:0] OP_LHU = 4'h4;
	localparam logic [OP_W-1:0] OP_LW  = 4'h5;
	localparam logic [OP_W-1:0] OP_SB  = 4'h6;
	localparam logic [OP_W-1:0] OP_SH  = 4'h7;
	localparam logic [OP_W-1:0] OP_SW  = 4'h8;

	// linked pair
	localparam logic [OP_W-1:0] OP_LL  = 4'h9;
	localparam logic [OP_W-1:0] OP_SC  = 4'ha;

	////////////////////////////////////////
	// exception codes
	////////////////////////////////////////

	localparam logic [EXC_W-1:0] EXC_NONE = 5'd0;
	// address error on load
	localparam logic [EXC_W-1:0] EXC_ADEL = 5'd4;
	// address error on store
	localparam logic [EXC_W-1:0] EXC_ADES = 5'd5;

	////////////////////////////////////////
	// bus master states
	////////////////////////////////////////

	localparam logic BM_IDLE = 1'b0;
	localparam logic BM_WAIT = 1'b1;

	////////////////////////////////////////
	// data word views
	////////////////////////////////////////

	// byte lane 0 sits in bits 7:0, half 0 in bits 15:0
	typedef union packed {
		logic [SEL_W-1:0][7:0]    bytes;
		logic [1:0][DATA_W/2-1:0] halves;
	} mem_word_u;

endpackage

/* lsu_result.sv */
`timescale 1ns/1ps

module lsu_result (
	input  logic                           clk,
	input  logic                           rst_i,
	input  logic                           bus_done_i,
	input  logic                           skip_i,
	input  logic                           fault_i,
	input  logic                           is_load_i,
	input  logic                           is_store_i,
	input  logic                           is_signed_i,
	input  logic                           size_byte_i,
	input  logic                           size_half_i,
	input  logic                           is_ll_i,
	input  logic                           is_sc_i,
	input  logic [lsu_pkg::DATA_W-1:0]     addr_i,
	input  logic [lsu_pkg::DATA_W-1:0]     wb_dat_i,
	input  logic [lsu_pkg::REG_ADDR_W-1:0] wd_i,
	input  logic                           llbit_clr_i,
	output logic                           link_o,
	output logic                           done_o,
	output logic                           wreg_o,
	output logic [lsu_pkg::REG_ADDR_W-1:0] wd_o,
	output logic [lsu_pkg::DATA_W-1:0]     wdata_o,
	output logic [lsu_pkg::EXC_W-1:0]      exc_code_o,
	output logic [lsu_pkg::DATA_W-1:0]     badaddr_o
);
	import lsu_pkg::*;

	mem_word_u               rdata_q;
	logic [7:0]              lane_b;
	logic [DATA_W/2-1:0]     lane_h;
	logic [DATA_W-1:0]       load_val;
	logic                    finish;
	logic                    sc_pass_q;

	assign finish = bus_done_i | skip_i;

	////////////////////////////////////////
	// load data path
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (bus_done_i)
			rdata_q <= wb_dat_i;
	end

	assign lane_b = rdata_q.bytes[addr_i[1:0]];
	assign lane_h = rdata_q.halves[addr_i[1]];

	always_comb
	begin
		if (size_byte_i)
			load_val = {{(DATA_W-8){is_signed_i & lane_b[7]}}, lane_b};
		else if (size_half_i)
			load_val = {{(DATA_W/2){is_signed_i & lane_h[DATA_W/2-1]}}, lane_h};
		else
			load_val = rdata_q;
	end

	// SC reports pass/fail instead of data
	assign wdata_o = is_sc_i ? {{(DATA_W-1){1'b0}}, sc_pass_q} : load_val;

	////////////////////////////////////////
	// link bit
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst_i || llbit_clr_i)
			link_o <= 1'b0;
		else if (bus_done_i && is_ll_i)
			link_o <= 1'b1;
		else if (bus_done_i && is_sc_i)
			link_o <= 1'b0;
	end

	////////////////////////////////////////
	// completion and exceptions
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			done_o     <= 1'b0;
			wreg_o     <= 1'b0;
			sc_pass_q  <= 1'b0;
			exc_code_o <= EXC_NONE;
		end
		else
		begin
			done_o <= finish;
			// failed SC still writes its zero
			wreg_o <= (bus_done_i & (is_load_i | is_sc_i)) | (skip_i & is_sc_i & ~fault_i);
			if (finish)
			begin
				sc_pass_q <= bus_done_i;
				if (skip_i && fault_i)
					exc_code_o <= is_store_i ? EXC_ADES : EXC_ADEL;
				else
					exc_code_o <= EXC_NONE;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (finish)
		begin
			wd_o      <= wd_i;
			badaddr_o <= fault_i ? addr_i : {DATA_W{1'b0}};
		end
	end

endmodule

/* lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
	input  logic                           clk,
	input  logic                           rst_i,
	input  logic                           req_valid_i,
	input  logic [lsu_pkg::OP_W-1:0]       op_i,
	input  logic [lsu_pkg::DATA_W-1:0]     addr_i,
	input  logic [lsu_pkg::DATA_W-1:0]     store_data_i,
	input  logic [lsu_pkg::REG_ADDR_W-1:0] wd_i,
	input  logic                           llbit_clr_i,
	output logic                           busy_o,
	output logic                           done_o,
	output logic                           wreg_o,
	output logic [lsu_pkg::REG_ADDR_W-1:0] wd_o,
	output logic [lsu_pkg::DATA_W-1:0]     wdata_o,
	output logic [lsu_pkg::EXC_W-1:0]      exc_code_o,
	output logic [lsu_pkg::DATA_W-1:0]     badaddr_o,
	output logic                           wb_cyc_o,
	output logic                           wb_stb_o,
	output logic                           wb_we_o,
	output logic [lsu_pkg::DATA_W-1:0]     wb_adr_o,
	output logic [lsu_pkg::SEL_W-1:0]      wb_sel_o,
	output logic [lsu_pkg::DATA_W-1:0]     wb_dat_o,
	input  logic [lsu_pkg::DATA_W-1:0]     wb_dat_i,
	input  logic                           wb_ack_i
);
	import lsu_pkg::*;

	logic                  accept;
	logic                  busy_q;
	logic [REG_ADDR_W-1:0] wd_q;
	logic                  is_load;
	logic                  is_store;
	logic                  is_signed;
	logic                  size_byte;
	logic                  size_half;
	logic                  is_ll;
	logic                  is_sc;
	logic                  start;
	logic                  skip;
	logic                  fault;
	logic                  link;
	logic                  bus_done;
	logic [SEL_W-1:0]      sel;
	logic [DATA_W-1:0]     store_lanes;
	logic [DATA_W-1:0]     req_addr;

	////////////////////////////////////////
	// request handshake
	////////////////////////////////////////

	assign accept = req_valid_i & ~busy_q;
	assign busy_o = busy_q;

	always_ff @(posedge clk)
	begin
		if (rst_i)
			busy_q <= 1'b0;
		else if (accept)
			busy_q <= 1'b1;
		else if (done_o)
			busy_q <= 1'b0;
	end

	// destination register rides along with the request
	always_ff @(posedge clk)
	begin
		if (accept)
			wd_q <= wd_i;
	end

	////////////////////////////////////////
	// stages
	////////////////////////////////////////

	lsu_decode u_decode (
		.clk(clk), .rst_i(rst_i), .accept_i(accept), .op_i(op_i),
		.addr_i(addr_i), .store_data_i(store_data_i), .link_i(link),
		.is_load_o(is_load), .is_store_o(is_store), .is_signed_o(is_signed),
		.size_byte_o(size_byte), .size_half_o(size_half), .is_ll_o(is_ll),
		.is_sc_o(is_sc), .start_o(start), .skip_o(skip), .sel_o(sel),
		.store_lanes_o(store_lanes), .addr_o(req_addr), .fault_o(fault)
	);

	lsu_bus_master u_bus (
		.clk(clk), .rst_i(rst_i), .start_i(start), .is_store_i(is_store),
		.addr_i(req_addr), .sel_i(sel), .store_lanes_i(store_lanes),
		.wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
		.wb_adr_o(wb_adr_o), .wb_sel_o(wb_sel_o), .wb_dat_o(wb_dat_o),
		.wb_ack_i(wb_ack_i), .bus_done_o(bus_done)
	);

	lsu_result u_result (
		.clk(clk), .rst_i(rst_i), .bus_done_i(bus_done), .skip_i(skip),
		.fault_i(fault), .is_load_i(is_load), .is_store_i(is_store),
		.is_signed_i(is_signed), .size_byte_i(size_byte), .size_half_i(size_half),
		.is_ll_i(is_ll), .is_sc_i(is_sc), .addr_i(req_addr), .wb_dat_i(wb_dat_i),
		.wd_i(wd_q), .llbit_clr_i(llbit_clr_i), .link_o(link), .done_o(done_o),
		.wreg_o(wreg_o), .wd_o(wd_o), .wdata_o(wdata_o), .exc_code_o(exc_code_o),
		.badaddr_o(badaddr_o)
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# build the LSU testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_lsu -Mdir "$BUILD_DIR" -f sources.f
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_lsu" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
	echo "result: PASS"
	exit 0
fi

echo "result: FAIL"
exit 1

/* sources.f */
lsu_pkg.sv
lsu_decode.sv
lsu_bus_master.sv
lsu_result.sv
lsu_top.sv
tb_lsu_sva.sv
tb_lsu.sv

/* tb_lsu.sv */
`timescale 1ns/1ps

module tb_lsu;
	import lsu_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int MEM_WORDS  = 64;
	localparam int RAND_REQS  = 40;
	// total request count of all tests
	localparam int NUM_REQS = 1 + 3 * 14 + 12 + 10 + 8 + RAND_REQS + MEM_WORDS;

	logic                  clk;
	logic                  rst_i;
	logic                  req_valid_i;
	logic [OP_W-1:0]       op_i;
	logic [DATA_W-1:0]     addr_i;
	logic [DATA_W-1:0]     store_data_i;
	logic [REG_ADDR_W-1:0] wd_i;
	logic                  llbit_clr_i;
	logic                  busy_o;
	logic                  done_o;
	logic                  wreg_o;
	logic [REG_ADDR_W-1:0] wd_o;
	logic [DATA_W-1:0]     wdata_o;
	logic [EXC_W-1:0]      exc_code_o;
	logic [DATA_W-1:0]     badaddr_o;
	logic                  wb_cyc_o;
	logic                  wb_stb_o;
	logic                  wb_we_o;
	logic [DATA_W-1:0]     wb_adr_o;
	logic [SEL_W-1:0]      wb_sel_o;
	logic [DATA_W-1:0]     wb_dat_o;
	logic [DATA_W-1:0]     wb_dat_i;
	logic                  wb_ack_i;

	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic [DATA_W-1:0] shadow [MEM_WORDS];
	logic              model_link;
	logic              in_wait;
	int                wait_left;
	int                seed;
	int                bus_cycles;
	int                done_count;
	int                req_count;

	lsu_top uut (.*);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic fail_run(input string reason);
		$display("Verification failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input string field,
		input logic [DATA_W-1:0] exp_v, input logic [DATA_W-1:0] act_v);
		assert (act_v === exp_v)
		else
		begin
			$display("Mismatch in %s (%s): expected %h, actual %h", name, field, exp_v, act_v);
			fail_run("result check failed");
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	////////////////////////////////////////
	// wishbone memory with 0 to 3 wait states
	////////////////////////////////////////

	function automatic logic [DATA_W-1:0] fill_word(input int idx);
		logic [7:0] b;
		b = idx[7:0];
		return {b, ~b, b * 8'd7 + 8'd3, b ^ 8'ha5};
	endfunction

	always @(posedge clk)
	begin
		logic [5:0] widx;
		#1;
		widx = wb_adr_o[7:2];
		if (wb_ack_i)
			wb_ack_i = 1'b0;
		else if (wb_cyc_o && wb_stb_o)
		begin
			if (!in_wait)
			begin
				wait_left = $random(seed) & 3;
				in_wait = 1'b1;
			end
			if (wait_left == 0)
			begin
				assert (wb_adr_o[1:0] == 2'b00 && wb_adr_o[31:8] == 24'h0)
				else
					fail_run("bus address not word aligned or outside the memory");
				for (int l = 0; l < SEL_W; l++)
				begin
					if (wb_we_o && wb_sel_o[l])
						mem[widx][8*l +: 8] = wb_dat_o[8*l +: 8];
				end
				wb_dat_i = mem[widx];
				wb_ack_i = 1'b1;
				in_wait = 1'b0;
				bus_cycles++;
			end
			else
				wait_left--;
		end
	end

	always @(negedge clk)
	begin
		if (done_o && !rst_i)
			done_count++;
		if (uut.sva_chk.err_count != 0)
			fail_run("a bus or handshake assertion failed");
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	function automatic logic [DATA_W-1:0] expect_load(input logic [OP_W-1:0] op,
		input logic [DATA_W-1:0] word, input logic [1:0] off);
		logic [7:0]  b;
		logic [15:0] h;
		b = word[8*off +: 8];
		h = off[1] ? word[31:16] : word[15:0];
		case (op)
			OP_LB:   return {{24{b[7]}}, b};
			OP_LBU:  return {24'h0, b};
			OP_LH:   return {{16{h[15]}}, h};
			OP_LHU:  return {16'h0, h};
			default: return word;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] merge_store(input logic [OP_W-1:0] op,
		input logic [DATA_W-1:0] old, input logic [DATA_W-1:0] data, input logic [1:0] off);
		logic [DATA_W-1:0] res;
		res = old;
		case (op)
			OP_SB:   res[8*off +: 8] = data[7:0];
			OP_SH:   res[16*off[1] +: 16] = data[15:0];
			default: res = data;
		endcase
		return res;
	endfunction

	function automatic logic misaligned(input logic [OP_W-1:0] op, input logic [1:0] off);
		case (op)
			OP_LH, OP_LHU, OP_SH:       return off[0];
			OP_LW, OP_SW, OP_LL, OP_SC: return off != 2'b00;
			default:                    return 1'b0;
		endcase
	endfunction

	// issue one request and check it on done_o
	task automatic run_req(input string name, input logic [OP_W-1:0] op,
		input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data, input logic spoil);
		logic [5:0]            idx;
		logic                  load;
		logic                  store;
		logic                  fault;
		logic                  use_bus;
		logic                  exp_wreg;
		logic [EXC_W-1:0]      exp_exc;
		logic [DATA_W-1:0]     exp_data;
		logic [REG_ADDR_W-1:0] reg_idx;
		int                    cycles_before;
		idx = addr[7:2];
		load = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LL};
		store = op inside {OP_SB, OP_SH, OP_SW, OP_SC};
		fault = misaligned(op, addr[1:0]);
		use_bus = (load || store) && !fault && !(op == OP_SC && !model_link);
		exp_wreg = !fault && (load || op == OP_SC);
		exp_exc = fault ? (store ? EXC_ADES : EXC_ADEL) : EXC_NONE;
		exp_data = expect_load(op, shadow[idx], addr[1:0]);
		if (op == OP_SC)
			exp_data = {31'h0, model_link};
		if (use_bus && store)
			shadow[idx] = merge_store(op, shadow[idx], data, addr[1:0]);
		if (op == OP_LL && !fault)
			model_link = 1'b1;
		if (op == OP_SC && use_bus)
			model_link = 1'b0;
		reg_idx = 5'(req_count + 1);

		while (busy_o)
			next_cycle();
		cycles_before = bus_cycles;
		req_valid_i = 1'b1;
		op_i = op;
		addr_i = addr;
		store_data_i = data;
		wd_i = reg_idx;
		next_cycle();
		req_count++;
		// a competing store that must be ignored while busy
		req_valid_i = spoil;
		op_i = OP_SW;
		addr_i = 32'h0000_00fc;
		store_data_i = 32'hdead_beef;
		while (!done_o)
			next_cycle();
		req_valid_i = 1'b0;

		check_value(name, "exc_code", 32'(exp_exc), 32'(exc_code_o));
		check_value(name, "wreg", 32'(exp_wreg), 32'(wreg_o));
		check_value(name, "bus cycles", use_bus ? 1 : 0, bus_cycles - cycles_before);
		if (fault)
			check_value(name, "badaddr", addr, badaddr_o);
		if (exp_wreg)
		begin
			check_value(name, "wd", 32'(reg_idx), 32'(wd_o));
			check_value(name, "wdata", exp_data, wdata_o);
		end
	endtask

	task automatic word_lanes(input int idx, input logic [DATA_W-1:0] pattern);
		logic [DATA_W-1:0] base;
		base = 32'(idx) << 2;
		run_req("sw pattern", OP_SW, base, pattern, 1'b0);
		for (int k = 0; k < 4; k++)
		begin
			run_req("lb lane", OP_LB, base + 32'(k), 32'h0, 1'b0);
			run_req("lbu lane", OP_LBU, base + 32'(k), 32'h0, 1'b0);
		end
		for (int k = 0; k < 4; k += 2)
		begin
			run_req("lh half", OP_LH, base + 32'(k), 32'h0, 1'b0);
			run_req("lhu half", OP_LHU, base + 32'(k), 32'h0, 1'b0);
		end
		run_req("lw word", OP_LW, base, 32'h0, 1'b0);
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial
	begin
		logic [DATA_W-1:0] addr;
		logic [3:0]        pick;
		logic [OP_W-1:0]   ops [10];
		ops = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW, OP_LL, OP_SC};
		seed = 32'h70a8;
		rst_i = 1'b1;
		req_valid_i = 1'b0;
		op_i = '0;
		addr_i = '0;
		store_data_i = '0;
		wd_i = '0;
		llbit_clr_i = 1'b0;
		wb_dat_i = '0;
		wb_ack_i = 1'b0;
		model_link = 1'b0;
		in_wait = 1'b0;
		wait_left = 0;
		bus_cycles = 0;
		done_count = 0;
		req_count = 0;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			mem[i] = fill_word(i);
			shadow[i] = mem[i];
		end
		repeat (5) @(posedge clk);
		#1;
		assert (!busy_o && !done_o && !wreg_o && !wb_cyc_o && !wb_stb_o && !wb_we_o)
		else
			fail_run("outputs not idle while reset is held");
		rst_i = 1'b0;

		// link bit comes out of reset clear
		run_req("sc after reset", OP_SC, 32'h10, 32'h1234_5678, 1'b0);

		word_lanes(5, 32'h80ff_7f01);
		word_lanes(6, 32'h7f80_01fe);
		word_lanes(7, 32'hc3a5_5a3c);

		// partial stores into word 10
		for (int k = 0; k < 4; k++)
		begin
			run_req("sb lane", OP_SB, 32'h28 + 32'(k), $random(seed), 1'b0);
			run_req("lw after sb", OP_LW, 32'h28, 32'h0, 1'b0);
		end
		for (int k = 0; k < 4; k += 2)
		begin
			run_req("sh half", OP_SH, 32'h28 + 32'(k), $random(seed), 1'b0);
			run_req("lw after sh", OP_LW, 32'h28, 32'h0, 1'b0);
		end

		// misaligned accesses on word 12
		run_req("lh odd", OP_LH, 32'h31, 32'h0, 1'b0);
		run_req("lh odd upper", OP_LH, 32'h33, 32'h0, 1'b0);
		run_req("lhu odd", OP_LHU, 32'h31, 32'h0, 1'b0);
		for (int k = 1; k < 4; k++)
			run_req("lw misaligned", OP_LW, 32'h30 + 32'(k), 32'h0, 1'b0);
		run_req("sh odd", OP_SH, 32'h31, 32'hffff_ffff, 1'b0);
		for (int k = 2; k < 4; k++)
			run_req("sw misaligned", OP_SW, 32'h30 + 32'(k), 32'hffff_ffff, 1'b0);
		run_req("lw after faults", OP_LW, 32'h30, 32'h0, 1'b0);

		// linked pair on word 20
		run_req("ll", OP_LL, 32'h50, 32'h0, 1'b0);
		run_req("sc linked", OP_SC, 32'h50, 32'h1357_9bdf, 1'b0);
		run_req("sc unlinked", OP_SC, 32'h50, 32'h2468_ace0, 1'b0);
		run_req("lw after sc", OP_LW, 32'h50, 32'h0, 1'b0);
		run_req("ll before clear", OP_LL, 32'h50, 32'h0, 1'b0);
		llbit_clr_i = 1'b1;
		next_cycle();
		llbit_clr_i = 1'b0;
		model_link = 1'b0;
		run_req("sc after clear", OP_SC, 32'h50, 32'h0bad_0bad, 1'b0);
		run_req("lw after clear", OP_LW, 32'h50, 32'h0, 1'b0);
		run_req("no-op", 4'hf, 32'h51, 32'h0, 1'b0);

		// random mix with blocked requests while busy
		for (int n = 0; n < RAND_REQS; n++)
		begin
			pick = 4'($unsigned($random(seed)) % 10);
			addr = 32'($random(seed)) & 32'h7f;
			run_req("random", ops[pick], addr, $random(seed), 1'b1);
		end
		for (int i = 0; i < MEM_WORDS; i++)
			run_req("final sweep", OP_LW, 32'(i) << 2, 32'h0, 1'b0);

		next_cycle();
		check_value("end of run", "done pulses", req_count, done_count);
		if (uut.sva_chk.err_count != 0)
			fail_run("a bus or handshake assertion failed");
		else
		begin
			$display("Verification passed");
			$finish;
		end
	end

	initial
	begin
		repeat (NUM_REQS * 20 + 10) @(posedge clk);
		fail_run("watchdog expired before all requests completed");
	end

endmodule

/* tb_lsu_sva.sv */
`timescale 1ns/1ps

module tb_lsu_sva (
	input logic                       clk,
	input logic                       rst_i,
	input logic                       cyc_i,
	input logic                       stb_i,
	input logic                       we_i,
	input logic [lsu_pkg::DATA_W-1:0] adr_i,
	input logic [lsu_pkg::SEL_W-1:0]  sel_i,
	input logic [lsu_pkg::DATA_W-1:0] dat_i,
	input logic                       ack_i,
	input logic                       skip_i,
	input logic                       busy_i,
	input logic                       done_i,
	input logic                       wreg_i
);

	int err_count = 0;

	////////////////////////////////////////
	// wishbone classic rules
	////////////////////////////////////////

	stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i) stb_i |-> cyc_i)
	else
	begin
		err_count++;
		$error("wb_stb_o high outside a bus cycle");
	end

	// request fields frozen until the slave acks
	hold_until_ack: assert property (@(posedge clk) disable iff (rst_i)
		(cyc_i && stb_i && !ack_i) |=> (cyc_i && stb_i && $stable(adr_i) && $stable(sel_i)
		&& $stable(we_i) && $stable(dat_i)))
	else
	begin
		err_count++;
		$error("bus cycle dropped or changed before ack");
	end

	////////////////////////////////////////
	// unit handshake
	////////////////////////////////////////

	done_after_ack: assert property (@(posedge clk) disable iff (rst_i)
		(cyc_i && stb_i && ack_i) |=> done_i)
	else
	begin
		err_count++;
		$error("done_o missing in the cycle after ack");
	end

	done_single: assert property (@(posedge clk) disable iff (rst_i) done_i |=> !done_i)
	else
	begin
		err_count++;
		$error("done_o held for more than one cycle");
	end

	// skipped requests never touch the bus
	skip_no_bus: assert property (@(posedge clk) disable iff (rst_i) skip_i |-> !cyc_i)
	else
	begin
		err_count++;
		$error("bus cycle started on a skipped request");
	end

	reset_idle: assert property (@(posedge clk)
		rst_i |=> (!busy_i && !done_i && !wreg_i && !cyc_i && !stb_i && !we_i))
	else
	begin
		err_count++;
		$error("outputs not idle after reset edge");
	end

endmodule

bind lsu_top tb_lsu_sva sva_chk (
	.clk(clk), .rst_i(rst_i), .cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .we_i(wb_we_o),
	.adr_i(wb_adr_o), .sel_i(wb_sel_o), .dat_i(wb_dat_o), .ack_i(wb_ack_i),
	.skip_i(skip), .busy_i(busy_o), .done_i(done_o), .wreg_i(wreg_o)
);
